// ==== project.f ====
+incdir+design
design/cga_pkg.sv
design/pcr_load_decode.sv
design/pcr_register.sv
design/pcr_select.sv
design/cga_pcr_bank.sv
bench/tb_cga_pcr_bank.sv

// ==== run.sh ====
#!/bin/sh
# Build the PCR bank testbench with Verilator and run it.
# The run passes only if the simulation prints the pass message.

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_cga_pcr_bank \
  -o sim_tb_cga_pcr_bank &&
./obj_dir/sim_tb_cga_pcr_bank | tee /dev/stderr | grep "Regression passed" > /dev/null ||
{ echo "PCR bank simulation did not pass"; exit 1; }

echo "PCR bank simulation passed"

// ==== bench/tb_cga_pcr_bank.sv ====
/*
  Table driven testbench for the PCR bank
  Each row is driven 0.5 ns after a rising edge and held one cycle with lldpcr,
  then lldpcr drops and paging is checked after one more edge
  Paging is also checked after the first edge, before the write shows up
  Expected values come from a 16 entry model of the write and readback rules
  Stops at the first mismatch; a cycle limit guards against a hang
*/
`default_nettype none

`include "cga_macros.svh"

module tb_cga_pcr_bank;

  timeunit 1ns;
  timeprecision 100ps;

  // One stimulus row
  typedef struct packed {
    logic            lldpcr;
    logic            mclk_n;
    cga_pkg::pcr_t   fidbo;
    cga_pkg::level_t pil;
  } row_t;

  logic             sysclk;
  logic             reset;
  cga_pkg::pcr_t    fidbo;
  logic             lldpcr;
  logic             mclk_n;
  cga_pkg::level_t  pil;
  cga_pkg::paging_t paging;

  row_t          stim_q [$];              // Stimulus table
  cga_pkg::pcr_t model [`CGA_LEVELS];     // Expected stored words, level field zero
  int            cycle_count = 0;
  int            cycle_limit = 0;         // Set once the table is built

  cga_pcr_bank dut0 (
    .sysclk (sysclk),
    .reset  (reset),
    .fidbo  (fidbo),
    .lldpcr (lldpcr),
    .mclk_n (mclk_n),
    .pil    (pil),
    .paging (paging)
  );

  // 4 ns clock
  initial begin
    sysclk = 1'b0;
    forever #2 sysclk = ~sysclk;
  end

  // Cycle limit
  always @(posedge sysclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: checks did not finish");
      $display("Regression failed");
      $fatal(1, "cycle limit of %0d reached", cycle_limit);
    end
  end

  // Put a level number into bits 6:3 of a data word
  function automatic cga_pkg::pcr_t with_level(input logic [15:0] data,
                                               input cga_pkg::level_t lvl);
    logic [15:0] bits;
    bits = data;
    bits[`CGA_PIL_MSB:`CGA_PIL_LSB] = lvl;
    return bits;
  endfunction

  // Readback rule: stored word, PIL in 6:3, fields cut from fixed bit positions
  function automatic cga_pkg::paging_t expected_paging(input cga_pkg::pcr_t word,
                                                       input cga_pkg::level_t lvl);
    logic [15:0]      bits;
    cga_pkg::paging_t exp;
    bits = word;
    bits[`CGA_PIL_MSB:`CGA_PIL_LSB] = lvl;
    exp.pcr            = bits;
    exp.page_table     = bits[14:13];
    exp.alt_page_table = bits[10:9];
    exp.ring           = bits[2:0];
    return exp;
  endfunction

  // Write rule: both strobes high, target from 6:3, those bits not kept
  task automatic model_write(input row_t r);
    logic [15:0]     bits;
    cga_pkg::level_t lvl;
    bits = r.fidbo;
    lvl  = bits[`CGA_PIL_MSB:`CGA_PIL_LSB];
    if (r.lldpcr && r.mclk_n) begin
      bits[`CGA_PIL_MSB:`CGA_PIL_LSB] = '0;
      model[lvl] = bits;
    end
  endtask

  task automatic check_paging(input cga_pkg::paging_t expected,
                              input cga_pkg::paging_t actual);
    if (actual !== expected) begin
      $display("MISMATCH paging expected %h actual %h", expected, actual);
      $display("Regression failed");
      $fatal(1, "paging compare");
    end
  endtask

  task automatic check_pcr(input cga_pkg::pcr_t expected,
                           input cga_pkg::pcr_t actual);
    if (actual !== expected) begin
      $display("MISMATCH paging.pcr expected %h actual %h", expected, actual);
      $display("Regression failed");
      $fatal(1, "pcr compare");
    end
  endtask

  task automatic add_row(input logic l, input logic m, input cga_pkg::pcr_t word,
                         input cga_pkg::level_t p);
    row_t r;
    r.lldpcr = l;
    r.mclk_n = m;
    r.fidbo  = word;
    r.pil    = p;
    stim_q.push_back(r);
  endtask

  // Drive one row, check after the strobe edge and again after the next
  task automatic apply_row(input row_t r);
    cga_pkg::paging_t exp;
    lldpcr = r.lldpcr;
    mclk_n = r.mclk_n;
    fidbo  = r.fidbo;
    pil    = r.pil;
    exp = expected_paging(model[r.pil], r.pil);  // New pil, old register contents
    @(posedge sysclk);
    #0.5;
    lldpcr = 1'b0;                        // Rest of the row held
    check_paging(exp, paging);            // One cycle from pil to paging
    model_write(r);
    exp = expected_paging(model[r.pil], r.pil);
    @(posedge sysclk);
    #0.5;                                 // paging settled after the edge
    check_pcr(exp.pcr, paging.pcr);
    check_paging(exp, paging);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    // Fresh bank, every level reads as zero apart from the PIL
    for (int i = 0; i < `CGA_LEVELS; i++) begin
      add_row(1'b0, 1'b0, '0, cga_pkg::level_t'(i));
    end
    add_row(1'b1, 1'b1, with_level(16'hd5a6, 4'd5), 4'd5);  // Write level 5
    add_row(1'b0, 1'b0, '0, 4'd4);                          // Neighbours untouched
    add_row(1'b0, 1'b0, '0, 4'd6);
    add_row(1'b1, 1'b1, with_level(16'h2b59, 4'd6), 4'd5);  // Write 6 while reading 5
    add_row(1'b0, 1'b0, '0, 4'd6);                          // PIL switch only
    add_row(1'b1, 1'b0, with_level(16'h7fff, 4'd5), 4'd5);  // mclk_n low
    add_row(1'b0, 1'b1, with_level(16'h0000, 4'd5), 4'd5);  // lldpcr low
    add_row(1'b1, 1'b1, 16'hffff, 4'd15);                   // All ones to level 15
    add_row(1'b0, 1'b0, 16'hffff, 4'd0);                    // Level field follows pil
    // Random word into every level, read back at once
    for (int i = 0; i < `CGA_LEVELS; i++) begin
      rnd = $urandom();
      add_row(1'b1, 1'b1, with_level(rnd[15:0], cga_pkg::level_t'(i)),
              cga_pkg::level_t'(i));
    end
    // Read back in reverse with noise on the bus
    for (int i = 0; i < `CGA_LEVELS; i++) begin
      rnd = $urandom();
      add_row(1'b0, 1'b1, rnd[15:0], cga_pkg::level_t'(`CGA_LEVELS - 1 - i));
    end
    // Random strobes, data and level
    for (int i = 0; i < 48; i++) begin
      rnd = $urandom();
      add_row(rnd[16], rnd[17], rnd[15:0], rnd[21:18]);
    end
  endtask

  initial begin
    reset  = 1'b1;
    lldpcr = 1'b0;
    mclk_n = 1'b0;
    fidbo  = '0;
    pil    = '0;
    void'($urandom(32'hf97b6ba4));
    for (int i = 0; i < `CGA_LEVELS; i++) begin
      model[i] = '0;
    end
    build_table();
    cycle_limit = 16 + 2 * stim_q.size() + 32;

    // Reset, with a strobe in the middle that must be ignored
    repeat (8) @(posedge sysclk);
    #0.5;
    lldpcr = 1'b1;
    mclk_n = 1'b1;
    fidbo  = with_level(16'hffff, 4'd2);
    @(posedge sysclk);
    #0.5;
    lldpcr = 1'b0;
    mclk_n = 1'b0;
    fidbo  = '0;
    repeat (7) @(posedge sysclk);
    #0.5;
    reset = 1'b0;
    check_paging('0, paging);             // Still the reset value

    foreach (stim_q[i]) begin
      apply_row(stim_q[i]);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/cga_pcr_bank.sv ====
/*
  PCR bank of the CPU gate array, one register per program level
  Write on a rising sysclk edge with lldpcr and mclk_n both high
  Target level is fidbo bits 6:3, which are not stored
  paging follows pil and the registers with one cycle of latency
*/
`default_nettype none

`include "cga_macros.svh"

module cga_pcr_bank (
  input  logic             sysclk,
  input  logic             reset,
  input  cga_pkg::pcr_t    fidbo,   // Bus word
  input  logic             lldpcr,  // Load PCR strobe
  input  logic             mclk_n,  // Clock phase level
  input  cga_pkg::level_t  pil,     // Current program level
  output cga_pkg::paging_t paging   // To memory management
);

  logic [`CGA_LEVELS-1:0] load_onehot;             // One write enable per level
  cga_pkg::pcr_t          pcr_array [`CGA_LEVELS]; // Register outputs

  // Strobe qualify and level decode
  pcr_load_decode u_load_decode (
    .sysclk      (sysclk),
    .reset       (reset),
    .lldpcr      (lldpcr),
    .mclk_n      (mclk_n),
    .fidbo       (fidbo),
    .load_onehot (load_onehot)
  );

  // One register per program level, all fed from the same bus word
  for (genvar i = 0; i < `CGA_LEVELS; i++) begin : g_level
    pcr_register u_pcr (
      .sysclk (sysclk),
      .reset  (reset),
      .load   (load_onehot[i]),
      .fidbo  (fidbo),
      .pcr    (pcr_array[i])
    );
  end

  // Readback of the current level
  pcr_select u_select (
    .sysclk    (sysclk),
    .reset     (reset),
    .pcr_array (pcr_array),
    .pil       (pil),
    .paging    (paging)
  );

endmodule

`default_nettype wire

// ==== design/pcr_select.sv ====
/*
  Current level PCR selector and paging decoder
  One registered stage from pil or pcr_array to paging
  paging is all zero, level field included, right after reset
  pil is assumed stable around the sampling edge
*/
`default_nettype none

`include "cga_macros.svh"

module pcr_select (
  input  logic             sysclk,
  input  logic             reset,
  input  cga_pkg::pcr_t    pcr_array [`CGA_LEVELS], // All level registers
  input  cga_pkg::level_t  pil,                     // Current program level
  output cga_pkg::paging_t paging                   // Registered decode
);

  cga_pkg::pcr_t    pcr_sel;     // Word of the current level
  cga_pkg::pcr_t    pcr_pil;     // Same word with the level filled in
  cga_pkg::paging_t paging_next;

  // Level mux
  assign pcr_sel = pcr_array[pil];

  // Stored word has zeros in 6:3, PIL goes there
  always_comb begin
    pcr_pil       = pcr_sel;
    pcr_pil.level = pil;
  end

  // Split out the fields the MMU looks at
  always_comb begin
    paging_next.pcr            = pcr_pil;
    paging_next.page_table     = pcr_pil.page_table;     // Bits 14:13
    paging_next.alt_page_table = pcr_pil.alt_page_table; // Bits 10:9
    paging_next.ring           = pcr_pil.ring;           // Bits 2:0
  end

  // Output stage
  always_ff @(posedge sysclk) begin
    if (reset) begin
      paging <= '0;
    end else begin
      paging <= paging_next;
    end
  end

  // PIL seen at an edge shows up in the level field one cycle later
  a_pil_latency: assert property (
    @(posedge sysclk) disable iff (reset)
    1'b1 |=> (paging.pcr.level == $past(pil))
  ) else $error("paging level does not follow pil");

endmodule

`default_nettype wire

// ==== design/pcr_register.sv ====
/*
  Paging control register of one program level
  Holds bits 15:7 and 2:0 of the bus word
  Bits 6:3 read back as zero; the selector inserts the PIL there
  Load is already qualified and decoded upstream
*/
`default_nettype none

`include "cga_macros.svh"

module pcr_register (
  input  logic          sysclk,
  input  logic          reset,
  input  logic          load,   // Qualified load for this level
  input  cga_pkg::pcr_t fidbo,  // Shared bus word
  output cga_pkg::pcr_t pcr     // Stored word, level field zero
);

  logic [`CGA_WORD_W-1:`CGA_PIL_MSB+1] stored_hi; // Bits 15:7
  logic [`CGA_PIL_LSB-1:0]             stored_lo; // Ring, bits 2:0

  // Level bits are skipped on capture
  always_ff @(posedge sysclk) begin
    if (reset) begin
      stored_hi <= '0;
      stored_lo <= '0;
    end else if (load) begin
      stored_hi <= fidbo[`CGA_WORD_W-1:`CGA_PIL_MSB+1];
      stored_lo <= fidbo[`CGA_PIL_LSB-1:0];
    end
  end

  // Reassemble with a zero hole where the level sits
  assign pcr = {stored_hi, cga_pkg::level_t'(0), stored_lo};

  // Level field must never leak out of a register
  a_level_zero: assert property (
    @(posedge sysclk) pcr.level == '0
  ) else $error("pcr level field not zero");

endmodule

`default_nettype wire

// ==== design/pcr_load_decode.sv ====
/*
  Load strobe qualifier and level decoder
  Purely combinational; sysclk only clocks the assertions
  No handshake, so each qualified strobe is a write
  Loads are held off while reset is high
*/
`default_nettype none

`include "cga_macros.svh"

module pcr_load_decode (
  input  logic                   sysclk,
  input  logic                   reset,
  input  logic                   lldpcr,      // Load PCR strobe
  input  logic                   mclk_n,      // Clock phase level
  input  cga_pkg::pcr_t          fidbo,       // Bus word, level field picks the target
  output logic [`CGA_LEVELS-1:0] load_onehot  // One load per program level
);

  logic load_qual;

  // Strobe only counts in the right clock phase
  assign load_qual = lldpcr & mclk_n;

  // Target level comes from bits 6:3 of the data word itself
  always_comb begin
    load_onehot = '0;
    for (int i = 0; i < `CGA_LEVELS; i++) begin
      load_onehot[i] = load_qual && !reset && (fidbo.level == cga_pkg::level_t'(i));
    end
  end

  // At most one level written per cycle
  a_load_onehot: assert property (
    @(posedge sysclk) $onehot0(load_onehot)
  ) else $error("load_onehot has more than one bit set");

  // A load bit implies both strobes and no reset
  a_load_qualified: assert property (
    @(posedge sysclk) (|load_onehot) |-> (lldpcr && mclk_n && !reset)
  ) else $error("load without qualified strobe");

endmodule

`default_nettype wire

// ==== design/cga_pkg.sv ====
/*
  Types shared by the PCR bank
  The pcr_t layout must add up to `CGA_WORD_W bits
  Field placement inside the stored bits is local to this design
*/
`default_nettype none

`include "cga_macros.svh"

package cga_pkg;

  // Program level number, same width as the level field
  typedef logic [`CGA_PIL_MSB-`CGA_PIL_LSB:0] level_t;

  // Page table selector
  typedef logic [1:0] ptab_t;

  // Protection ring
  typedef logic [2:0] ring_t;

  // PCR word as seen on the bus and at a register output
  typedef struct packed {
    logic   spare;          // Bit 15, stored only
    ptab_t  page_table;     // Normal page table
    logic [1:0] unused_hi;  // Bits 12:11, stored only
    ptab_t  alt_page_table; // Alternative page table
    logic [1:0] ring_hi;    // Extended ring bits, stored only
    level_t level;          // Written on the bus, never stored
    ring_t  ring;           // Protection ring
  } pcr_t;

  // Registered paging control for the memory management logic
  typedef struct packed {
    pcr_t  pcr;             // Selected word with the PIL inserted
    ptab_t page_table;
    ptab_t alt_page_table;
    ring_t ring;
  } paging_t;

endpackage

`default_nettype wire

// ==== design/cga_macros.svh ====
/*
  Architectural constants of the PCR bank
  Word width and level field position are fixed by the CPU and may not be changed
  The level field must span exactly log2 of the level count
*/
`ifndef CGA_MACROS_SVH
`define CGA_MACROS_SVH

// Program levels, one PCR each
`define CGA_LEVELS 16

// Bus and PCR word width
`define CGA_WORD_W 16

// Level field inside the PCR word, never stored
`define CGA_PIL_LSB 3
`define CGA_PIL_MSB 6

`endif
